//--- list.f
iopage_pkg.sv
intr_pkg.sv
clk_regs.sv
tt_regs.sv
iopage_merge.sv
iopage.sv
tb_iopage.sv

//--- tb_iopage.sv
// ==================================================
// testbench for the I/O page with serial tx looped back to rx.
// the model tracks enables, the line-clock monitor and the buffers.
// ==================================================

module tb_iopage
   import iopage_pkg::*;
   import intr_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_DIV    = 50;
   localparam int BAUD_DIV   = 8;
   localparam int N_RD       = 32;
   localparam int N_WR       = 24;
   localparam int N_BYTES    = 6;
   localparam int FRAME      = 10 * BAUD_DIV;
   localparam int MAX_CYCLES = 2 * (4 + 3 * (N_RD + 5) + 6 * N_WR + 40 + 2 * CLK_DIV + 40
                               + N_BYTES * (2 * FRAME + 40) + 2 * FRAME + 80);

   logic       clk;
   logic       rst;
   io_req_t    req;
   io_rsp_t    rsp;
   irq_t       irq;
   logic       intr_ack;
   logic       serial;

   integer     seed;
   int         cycles = 0;
   int         err_cnt;
   int         chk_cnt;
   int         test_err;

   int         tcnt;
   logic       lo_wr;
   logic       mon_m, clk_ie_m, rx_ie_m, tx_ie_m;
   logic       done_m, ready_m;
   logic [7:0] rbuf_m;

   logic [12:0] sel_list [3] = '{CLK_CSR_OFS, TT_RCSR_OFS, TT_XCSR_OFS};

   iopage #(.CLK_DIV(CLK_DIV), .BAUD_DIV(BAUD_DIV)) u_iopage (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .rsp      (rsp),
      .irq      (irq),
      .intr_ack (intr_ack),
      .tx       (serial),
      .rx       (serial)
   );

   always #10 clk = ~clk;

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("Timeout: the run stopped after %0d cycles before the tests ended.", cycles);
         $display("=== FAIL ===");
         $finish;
      end
   end

   function automatic logic same_word(logic [12:0] a, logic [12:0] b);
      return a[12:1] == b[12:1];
   endfunction

   function automatic logic is_reg(logic [12:0] a);
      return same_word(a, CLK_CSR_OFS) | same_word(a, TT_RCSR_OFS) | same_word(a, TT_RBUF_OFS)
             | same_word(a, TT_XCSR_OFS) | same_word(a, TT_XBUF_OFS);
   endfunction

   // ================================================
   // register model
   // ================================================
   always @(posedge clk)
   begin
      if (rst)
      begin
         tcnt     = 0;
         mon_m    = 1'b0;
         clk_ie_m = 1'b0;
         rx_ie_m  = 1'b0;
         tx_ie_m  = 1'b0;
      end
      else
      begin
         lo_wr = req.wr && !(req.byte_op && req.addr[0]);   // odd byte writes miss every live bit.
         if (tcnt == CLK_DIV - 1)
         begin
            tcnt  = 0;
            mon_m = 1'b1;
         end
         else
         begin
            tcnt = tcnt + 1;
            if (lo_wr && same_word(req.addr, CLK_CSR_OFS) && !req.wdata[7])
               mon_m = 1'b0;
         end
         if (lo_wr && same_word(req.addr, CLK_CSR_OFS))
            clk_ie_m = req.wdata[6];
         if (lo_wr && same_word(req.addr, TT_RCSR_OFS))
            rx_ie_m = req.wdata[6];
         if (lo_wr && same_word(req.addr, TT_XCSR_OFS))
            tx_ie_m = req.wdata[6];
      end
   end

   function automatic logic [15:0] model_word(logic [12:0] a);
      if (same_word(a, CLK_CSR_OFS))
         return {8'h00, mon_m, clk_ie_m, 6'b000000};
      if (same_word(a, TT_RCSR_OFS))
         return {8'h00, done_m, rx_ie_m, 6'b000000};
      if (same_word(a, TT_RBUF_OFS))
         return {8'h00, rbuf_m};
      if (same_word(a, TT_XCSR_OFS))
         return {8'h00, ready_m, tx_ie_m, 6'b000000};
      return 16'h0000;
   endfunction

   function automatic irq_t make_irq(logic r, logic [2:0] ipl, logic [7:0] vec);
      irq_t i;
      i.req    = r;
      i.ipl    = ipl;
      i.vector = vec;
      return i;
   endfunction

   // ================================================
   // bus tasks and compares
   // ================================================
   task automatic report_error(input string msg);
      err_cnt = err_cnt + 1;
      $display("Error at %0d ns: %s", $time, msg);
   endtask

   task automatic bus_write(input logic [12:0] a, input logic byte_op, input logic [15:0] d);
      @(posedge clk);
      #2;
      req = '{rd: 1'b0, wr: 1'b1, byte_op: byte_op, addr: a, wdata: d};
      @(posedge clk);
      #2;
      req = '0;
   endtask

   task automatic bus_read(input logic [12:0] a, output io_rsp_t r, output logic [15:0] mdl);
      @(posedge clk);
      #2;
      req = '{rd: 1'b1, wr: 1'b0, byte_op: 1'b0, addr: a, wdata: 16'h0000};
      mdl = model_word(a);                            // model state seen by the strobe.
      @(posedge clk);
      #2;
      req = '0;
      r   = rsp;
      if (r.valid !== 1'b1)
         report_error($sformatf("no response on the cycle after a read of %o", a));
   endtask

   task automatic check_rsp(input io_rsp_t got, input io_rsp_t exp, input logic [15:0] mask,
                            input string what);
      chk_cnt = chk_cnt + 1;
      if (got.no_decode !== exp.no_decode || (got.rdata & mask) !== (exp.rdata & mask))
      begin
         err_cnt = err_cnt + 1;
         $display("Mismatch at %0d ns: %s, got no_decode %b rdata %h, expected %b %h",
                  $time, what, got.no_decode, got.rdata, exp.no_decode, exp.rdata & mask);
      end
   endtask

   task automatic check_irq(input irq_t got, input irq_t exp, input string what);
      chk_cnt = chk_cnt + 1;
      if (got.req !== exp.req || got.ipl !== exp.ipl || got.vector !== exp.vector)
      begin
         err_cnt = err_cnt + 1;
         $display("Mismatch at %0d ns: %s, got req %b ipl %0d vector %o, expected %b %0d %o",
                  $time, what, got.req, got.ipl, got.vector, exp.req, exp.ipl, exp.vector);
      end
   endtask

   task automatic read_check(input logic [12:0] a, input logic [15:0] mask, input string what);
      io_rsp_t     r;
      io_rsp_t     e;
      logic [15:0] m;
      bus_read(a, r, m);
      e = '{valid: 1'b1, no_decode: !is_reg(a), rdata: m};
      check_rsp(r, e, mask, what);
   endtask

   task automatic wait_bit(input logic [12:0] a, input int bit_n, input int bound,
                           input string what);
      io_rsp_t     r;
      logic [15:0] m;
      int          start;
      start = cycles;
      bus_read(a, r, m);
      while (r.rdata[bit_n] !== 1'b1 && cycles - start < bound)
         bus_read(a, r, m);
      if (r.rdata[bit_n] !== 1'b1)
         report_error($sformatf("%s was not set within %0d cycles", what, bound));
   endtask

   task automatic pulse_ack();
      @(posedge clk);
      #2;
      intr_ack = 1'b1;
      @(posedge clk);
      #2;
      intr_ack = 1'b0;
   endtask

   task automatic end_test(input int n, input string name);
      $display("test %0d %s: %0d errors", n, name, err_cnt - test_err);
      test_err = err_cnt;
   endtask

   // ================================================
   // test sequence
   // ================================================
   initial
   begin
      logic [12:0] a;
      logic [15:0] d;
      logic [7:0]  b;
      logic        bo;
      int          sel;
      seed     = 32'hc74f_d9ac;
      clk      = 1'b0;
      rst      = 1'b1;
      req      = '0;
      intr_ack = 1'b0;
      err_cnt  = 0;
      chk_cnt  = 0;
      test_err = 0;
      done_m   = 1'b0;
      ready_m  = 1'b1;
      rbuf_m   = 'x;
      repeat (4) @(posedge clk);
      #2;
      rst = 1'b0;

      for (int k = 0; k < N_RD; k++)
      begin
         a = 13'($random(seed));
         while (is_reg(a))
            a = 13'($random(seed));
         read_check(a, 16'hffff, "read outside the register set");
      end
      read_check(CLK_CSR_OFS, 16'hffff, "clock CSR read");
      read_check(TT_RCSR_OFS, 16'hffff, "receive CSR read");
      read_check(TT_RBUF_OFS, 16'h0000, "receive buffer read");   // nothing received yet.
      read_check(TT_XCSR_OFS, 16'hffff, "transmit CSR read");
      read_check(TT_XBUF_OFS, 16'hffff, "transmit buffer read");
      end_test(1, "decode");

      for (int k = 0; k < N_WR; k++)
      begin
         sel = $unsigned($random(seed)) % 3;
         a   = (sel == 0) ? CLK_CSR_OFS : (sel == 1) ? TT_RCSR_OFS : TT_XCSR_OFS;
         d   = 16'($random(seed));
         bo  = 1'($random(seed));
         if (bo)
            a[0] = 1'($random(seed));
         bus_write(a, bo, d);
         a[0] = 1'b0;
         read_check(a, 16'hffff, "CSR read back after random write");
      end
      foreach (sel_list[i])
      begin
         bus_write(sel_list[i], 1'b0, 16'h0000);
         bus_write(sel_list[i] | 13'd1, 1'b1, 16'hffff);       // high byte holds no enable.
         read_check(sel_list[i], 16'hffff, "CSR after high byte write");
         bus_write(sel_list[i], 1'b1, 16'h00ff);
         read_check(sel_list[i], 16'hffff, "CSR after low byte write");
      end
      end_test(2, "CSR enables");

      bus_write(CLK_CSR_OFS, 1'b0, 16'o000100);
      wait_bit(CLK_CSR_OFS, 7, 2 * CLK_DIV, "line clock monitor");
      check_irq(irq, make_irq(1'b1, CLK_IPL, CLK_VEC), "line clock request");
      pulse_ack();
      check_irq(irq, make_irq(1'b0, 3'd0, 8'h00), "request after acknowledge");
      bus_write(CLK_CSR_OFS, 1'b0, 16'h0000);
      read_check(CLK_CSR_OFS, 16'hffff, "monitor after clearing write");
      end_test(3, "line clock");

      bus_write(TT_RCSR_OFS, 1'b0, 16'h0000);
      bus_write(TT_XCSR_OFS, 1'b0, 16'h0000);
      for (int k = 0; k < N_BYTES; k++)
      begin
         b      = 8'($random(seed));
         bo     = 1'($random(seed));
         d      = 16'($random(seed));
         d[7:0] = b;
         bus_write(TT_XBUF_OFS, bo, d);
         ready_m = 1'b0;
         read_check(TT_XCSR_OFS, 16'hffff, "transmit ready after XBUF write");
         wait_bit(TT_RCSR_OFS, 7, FRAME + 4 * BAUD_DIV, "receive done");
         done_m = 1'b1;
         rbuf_m = b;
         read_check(TT_RBUF_OFS, 16'hffff, "received byte");
         done_m = 1'b0;
         read_check(TT_RCSR_OFS, 16'hffff, "receive done after RBUF read");
         wait_bit(TT_XCSR_OFS, 7, 2 * BAUD_DIV, "transmit ready at frame end");
         ready_m = 1'b1;
      end
      end_test(4, "loopback");

      bus_write(CLK_CSR_OFS, 1'b0, 16'o000100);
      bus_write(TT_RCSR_OFS, 1'b0, 16'o000100);
      bus_write(TT_XCSR_OFS, 1'b0, 16'o000100);
      b = 8'($random(seed));
      bus_write(TT_XBUF_OFS, 1'b1, {8'h00, b});
      wait_bit(TT_RCSR_OFS, 7, FRAME + 4 * BAUD_DIV, "receive done with enables on");
      wait_bit(TT_XCSR_OFS, 7, 2 * BAUD_DIV, "transmit ready with enables on");
      bus_write(CLK_CSR_OFS, 1'b0, 16'h0000);   // a frame spans a tick, so clock is pending.
      check_irq(irq, make_irq(1'b1, CLK_IPL, CLK_VEC), "first presented request");
      pulse_ack();
      check_irq(irq, make_irq(1'b1, TT_IPL, TT_RX_VEC), "second presented request");
      pulse_ack();
      check_irq(irq, make_irq(1'b1, TT_IPL, TT_TX_VEC), "third presented request");
      pulse_ack();
      check_irq(irq, make_irq(1'b0, 3'd0, 8'h00), "request after last acknowledge");
      end_test(5, "priority");

      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

//--- iopage.sv
// ==================================================
// I/O page top: line clock, console terminal, merge.
// ==================================================

module iopage
   import iopage_pkg::*;
   import intr_pkg::*;
#(
   parameter int CLK_DIV  = 50,
   parameter int BAUD_DIV = 8
)
(
   input  logic    clk,
   input  logic    rst,
   input  io_req_t req,
   output io_rsp_t rsp,
   output irq_t    irq,
   input  logic    intr_ack,
   output logic    tx,
   input  logic    rx
);

   dev_rd_t rd_clk, rd_tt;
   irq_t    irq_clk, irq_tt;
   logic    ack_clk, ack_tt;

   clk_regs #(.CLK_DIV(CLK_DIV)) u_clk_regs (
      .clk (clk),
      .rst (rst),
      .req (req),
      .rd  (rd_clk),
      .irq (irq_clk),
      .ack (ack_clk)
   );

   tt_regs #(.BAUD_DIV(BAUD_DIV)) u_tt_regs (
      .clk (clk),
      .rst (rst),
      .req (req),
      .rd  (rd_tt),
      .irq (irq_tt),
      .ack (ack_tt),
      .tx  (tx),
      .rx  (rx)
   );

   iopage_merge u_iopage_merge (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .rd_clk   (rd_clk),
      .rd_tt    (rd_tt),
      .irq_clk  (irq_clk),
      .irq_tt   (irq_tt),
      .intr_ack (intr_ack),
      .rsp      (rsp),
      .irq      (irq),
      .ack_clk  (ack_clk),
      .ack_tt   (ack_tt)
   );

endmodule

//--- iopage_merge.sv
// ==================================================
// response register, no-decode flag and interrupt arbiter.
// response latency is one cycle for every address.
// ==================================================

module iopage_merge
   import iopage_pkg::*;
   import intr_pkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  io_req_t req,
   input  dev_rd_t rd_clk,
   input  dev_rd_t rd_tt,
   input  irq_t    irq_clk,
   input  irq_t    irq_tt,
   input  logic    intr_ack,
   output io_rsp_t rsp,
   output irq_t    irq,
   output logic    ack_clk,
   output logic    ack_tt
);

   logic        strobe;
   logic        any_decode;
   logic [15:0] sel_data;
   logic        rsp_valid;
   logic        rsp_nd;
   logic [15:0] rsp_data;
   logic        pick_clk;

   // ================================================
   // bus response
   // ================================================
   assign strobe     = req.rd | req.wr;
   assign any_decode = rd_clk.decode | rd_tt.decode;
   assign sel_data   = rd_clk.decode ? rd_clk.rdata :
                       rd_tt.decode  ? rd_tt.rdata  : 16'h0000;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rsp_valid <= 1'b0;
         rsp_nd    <= 1'b0;
      end
      else
      begin
         rsp_valid <= strobe;
         rsp_nd    <= strobe & ~any_decode;
      end
   end

   always_ff @(posedge clk)
   begin
      if (strobe)
         rsp_data <= sel_data;
   end

   assign rsp = '{valid: rsp_valid, no_decode: rsp_nd, rdata: rsp_data};

   // ================================================
   // interrupt priority and acknowledge steering
   // ================================================
   assign pick_clk = irq_clk.req & (~irq_tt.req | (irq_clk.ipl >= irq_tt.ipl));

   assign irq = pick_clk   ? irq_clk :
                irq_tt.req ? irq_tt  : '{req: 1'b0, ipl: 3'd0, vector: 8'h00};

   assign ack_clk = intr_ack & irq.req & pick_clk;
   assign ack_tt  = intr_ack & irq.req & ~pick_clk;   // only the presented source is cleared.

endmodule

//--- tt_regs.sv
// ==================================================
// console terminal with an 8N1 transmitter and receiver.
// XBUF writes while busy are dropped; a new byte overwrites RBUF.
// ==================================================

module tt_regs
   import iopage_pkg::*;
   import intr_pkg::*;
#(
   parameter int BAUD_DIV = 8
)
(
   input  logic    clk,
   input  logic    rst,
   input  io_req_t req,
   output dev_rd_t rd,
   output irq_t    irq,
   input  logic    ack,
   output logic    tx,
   input  logic    rx
);

   localparam int BW = $clog2(BAUD_DIV + 1);

   logic          sel_rcsr, sel_rbuf, sel_xcsr, sel_xbuf;
   logic          lo_we;
   logic          rx_ie, tx_ie;
   logic          rx_done;
   logic [7:0]    rbuf;
   logic          rx_pend, tx_pend;

   logic          tx_busy;
   logic [BW-1:0] tx_bcnt;
   logic [3:0]    tx_bit;
   logic [9:0]    tx_sh;
   logic          tx_samp, tx_start, tx_fin;

   logic          rx_s1, rx_s2;
   logic          rx_busy;
   logic [BW-1:0] rx_bcnt;
   logic [3:0]    rx_bit;
   logic [7:0]    rx_sh;
   logic          rx_samp, rx_load;

   assign sel_rcsr = (req.addr[12:1] == TT_RCSR_OFS[12:1]);
   assign sel_rbuf = (req.addr[12:1] == TT_RBUF_OFS[12:1]);
   assign sel_xcsr = (req.addr[12:1] == TT_XCSR_OFS[12:1]);
   assign sel_xbuf = (req.addr[12:1] == TT_XBUF_OFS[12:1]);
   assign lo_we    = lo_byte_wr(req);

   // ================================================
   // transmitter
   // ================================================
   assign tx_samp  = (tx_bcnt == BW'(BAUD_DIV - 1));
   assign tx_start = sel_xbuf & lo_we & ~tx_busy;
   assign tx_fin   = tx_busy & tx_samp & (tx_bit == 4'd9);   // end of the stop bit.
   assign tx       = tx_sh[0];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         tx_busy <= 1'b0;
         tx_bcnt <= '0;
         tx_bit  <= '0;
         tx_sh   <= '1;                              // line idles high.
      end
      else if (tx_start)
      begin
         tx_busy <= 1'b1;
         tx_bcnt <= '0;
         tx_bit  <= '0;
         tx_sh   <= {1'b1, req.wdata[7:0], 1'b0};    // stop, data lsb first, start.
      end
      else if (tx_busy)
      begin
         if (tx_samp)
         begin
            tx_bcnt <= '0;
            tx_bit  <= tx_bit + 1'b1;
            tx_sh   <= {1'b1, tx_sh[9:1]};
            if (tx_fin)
               tx_busy <= 1'b0;
         end
         else
            tx_bcnt <= tx_bcnt + 1'b1;
      end
   end

   // ================================================
   // receiver
   // ================================================
   assign rx_samp = rx_busy & (rx_bcnt == BW'(BAUD_DIV - 1));
   assign rx_load = rx_samp & (rx_bit == 4'd9) & rx_s2;   // framing errors are dropped.

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rx_s1   <= 1'b1;
         rx_s2   <= 1'b1;
         rx_busy <= 1'b0;
         rx_bcnt <= '0;
         rx_bit  <= '0;
      end
      else
      begin
         rx_s1 <= rx;
         rx_s2 <= rx_s1;
         if (!rx_busy)
         begin
            if (!rx_s2)
            begin
               rx_busy <= 1'b1;
               rx_bcnt <= BW'(BAUD_DIV / 2);         // first sample near mid start bit.
               rx_bit  <= '0;
            end
         end
         else if (rx_samp)
         begin
            rx_bcnt <= '0;
            rx_bit  <= rx_bit + 1'b1;
            if ((rx_bit == 4'd0 && rx_s2) || rx_bit == 4'd9)
               rx_busy <= 1'b0;                      // false start or frame done.
         end
         else
            rx_bcnt <= rx_bcnt + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rx_samp && rx_bit >= 4'd1 && rx_bit <= 4'd8)
         rx_sh <= {rx_s2, rx_sh[7:1]};
      if (rx_load)
         rbuf <= rx_sh;
   end

   // ================================================
   // CSRs and interrupt flags
   // ================================================
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rx_ie   <= 1'b0;
         tx_ie   <= 1'b0;
         rx_done <= 1'b0;
         rx_pend <= 1'b0;
         tx_pend <= 1'b0;
      end
      else
      begin
         if (sel_rcsr && lo_we)
            rx_ie <= req.wdata[6];
         if (sel_xcsr && lo_we)
            tx_ie <= req.wdata[6];

         if (rx_load)
            rx_done <= 1'b1;
         else if (req.rd && sel_rbuf)
            rx_done <= 1'b0;

         // receive is presented first, so ack clears it first.
         if (rx_load && rx_ie)
            rx_pend <= 1'b1;
         else if (ack && rx_pend)
            rx_pend <= 1'b0;

         if (tx_fin && tx_ie)
            tx_pend <= 1'b1;
         else if (ack && !rx_pend)
            tx_pend <= 1'b0;
      end
   end

   always_comb
   begin
      rd.decode = sel_rcsr | sel_rbuf | sel_xcsr | sel_xbuf;
      case (req.addr[2:1])
         2'd0:    rd.rdata = {8'h00, rx_done, rx_ie, 6'b000000};
         2'd1:    rd.rdata = {8'h00, rbuf};
         2'd2:    rd.rdata = {8'h00, ~tx_busy, tx_ie, 6'b000000};
         default: rd.rdata = 16'h0000;               // XBUF is write only.
      endcase
   end

   assign irq = rx_pend ? '{req: 1'b1, ipl: TT_IPL, vector: TT_RX_VEC} :
                tx_pend ? '{req: 1'b1, ipl: TT_IPL, vector: TT_TX_VEC} :
                          '{req: 1'b0, ipl: 3'd0, vector: 8'h00};

endmodule

//--- clk_regs.sv
// ==================================================
// line-time clock, one CSR. monitor is bit 7, enable bit 6.
// a tick every CLK_DIV cycles; the request holds until ack.
// ==================================================

module clk_regs
   import iopage_pkg::*;
   import intr_pkg::*;
#(
   parameter int CLK_DIV = 50
)
(
   input  logic    clk,
   input  logic    rst,
   input  io_req_t req,
   output dev_rd_t rd,
   output irq_t    irq,
   input  logic    ack
);

   localparam int CW = $clog2(CLK_DIV + 1);

   logic [CW-1:0] cnt;
   logic          tick;
   logic          sel;
   logic          csr_wr;
   logic          monitor;
   logic          ie;
   logic          pend;

   assign sel    = (req.addr[12:1] == CLK_CSR_OFS[12:1]);   // both bytes of the word.
   assign csr_wr = sel & lo_byte_wr(req);                   // all live bits are in the low byte.
   assign tick   = (cnt == CW'(CLK_DIV - 1));

   // ================================================
   // tick divider
   // ================================================
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         cnt <= '0;
      end
      else if (tick)
      begin
         cnt <= '0;
      end
      else
      begin
         cnt <= cnt + 1'b1;
      end
   end

   // ================================================
   // CSR and pending request
   // ================================================
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         monitor <= 1'b0;
         ie      <= 1'b0;
         pend    <= 1'b0;
      end
      else
      begin
         if (csr_wr)
            ie <= req.wdata[6];

         if (tick)
            monitor <= 1'b1;                        // a tick wins over a clearing write.
         else if (csr_wr && !req.wdata[7])
            monitor <= 1'b0;

         if (tick && ie)
            pend <= 1'b1;
         else if (ack)
            pend <= 1'b0;
      end
   end

   assign rd  = '{decode: sel, rdata: {8'h00, monitor, ie, 6'b000000}};
   assign irq = '{req: pend, ipl: CLK_IPL, vector: CLK_VEC};

endmodule

//--- intr_pkg.sv
// ==================================================
// interrupt request type, priority levels and vectors.
// ==================================================

package intr_pkg;

   // one pending request as presented to the processor.
   typedef struct packed {
      logic       req;
      logic [2:0] ipl;
      logic [7:0] vector;
   } irq_t;

   // ================================================
   // priority levels
   // ================================================
   localparam logic [2:0] CLK_IPL = 3'd6;
   localparam logic [2:0] TT_IPL  = 3'd4;

   // ================================================
   // vectors (octal)
   // ================================================
   localparam logic [7:0] CLK_VEC   = 8'o100;
   localparam logic [7:0] TT_RX_VEC = 8'o060;
   localparam logic [7:0] TT_TX_VEC = 8'o064;

endpackage

//--- iopage_pkg.sv
// ==================================================
// bus access types and I/O page register offsets.
// offsets are 13-bit byte addresses inside the page.
// ==================================================

package iopage_pkg;

   // one processor access, rd and wr are single-cycle strobes.
   typedef struct packed {
      logic        rd;
      logic        wr;
      logic        byte_op;
      logic [12:0] addr;
      logic [15:0] wdata;
   } io_req_t;

   // registered response, valid for one cycle after the strobe.
   typedef struct packed {
      logic        valid;
      logic        no_decode;
      logic [15:0] rdata;
   } io_rsp_t;

   // combinational reply of one device.
   typedef struct packed {
      logic        decode;
      logic [15:0] rdata;
   } dev_rd_t;

   // ================================================
   // register offsets (octal, as in the handbook)
   // ================================================
   localparam logic [12:0] CLK_CSR_OFS = 13'o17546;
   localparam logic [12:0] TT_RCSR_OFS = 13'o17560;
   localparam logic [12:0] TT_RBUF_OFS = 13'o17562;
   localparam logic [12:0] TT_XCSR_OFS = 13'o17564;
   localparam logic [12:0] TT_XBUF_OFS = 13'o17566;

   // a word write or a byte write to an even address touches the low byte.
   function automatic logic lo_byte_wr(io_req_t r);
      return r.wr & (~r.byte_op | ~r.addr[0]);
   endfunction

endpackage
